//--- common/emu_pkg.sv
`default_nettype none

package emu_pkg;

    // time step and half period width, in ticks
    localparam int dt_width = 24;
    typedef logic [dt_width-1:0] dt_t;

    // readback widths
    localparam int time_width = 32;
    localparam int edge_cnt_width = 16;

    // both half periods start here after reset
    localparam dt_t reset_half_period = dt_t'(4);

    // high and low half periods of one oscillator
    typedef struct packed {
        dt_t t_hi;
        dt_t t_lo;
    } osc_cfg_t;

    // axi4-lite, master side
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    // axi4-lite, slave side
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef enum logic [1:0] {
        axil_idle,
        axil_wresp,
        axil_rdata
    } axil_state_e;

    // register map
    localparam logic [7:0] reg_ctrl = 8'h00;
    localparam logic [7:0] reg_time = 8'h04;
    localparam logic [7:0] reg_osc_base = 8'h10;
    localparam logic [7:0] reg_edge_base = 8'h40;

endpackage

`default_nettype wire

//--- hw/axil_cfg_regs.sv
`timescale 1ns/1ns
`default_nettype none

module axil_cfg_regs #(
    parameter int num_osc = 2
) (
    input  wire logic                                            __emu_clk,
    input  wire logic                                            __emu_rst,
    input  wire emu_pkg::axil_req_t                              axil_req,
    output emu_pkg::axil_rsp_t                                   axil_rsp,
    output logic                                                 run,
    output emu_pkg::osc_cfg_t [num_osc-1:0]                      osc_cfg,
    input  wire logic [emu_pkg::time_width-1:0]                  emu_time,
    input  wire logic [num_osc-1:0][emu_pkg::edge_cnt_width-1:0] edge_cnt
);

    emu_pkg::axil_state_e state;
    logic                 write_go;
    logic                 read_go;
    logic [31:0]          rd_mux;
    logic [31:0]          rdata_q;

    // byte-merge a half period write, zero is stored as 1
    function automatic emu_pkg::dt_t merge_half(
        input emu_pkg::dt_t old_val,
        input logic [31:0]  data,
        input logic [3:0]   strb
    );
        logic [31:0] merged;
        merged = 32'(old_val);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        if (merged[emu_pkg::dt_width-1:0] == '0) begin
            merged = 32'd1;
        end
        return merged[emu_pkg::dt_width-1:0];
    endfunction

    // write wins when both channels are offered in idle
    assign write_go = (state == emu_pkg::axil_idle) && axil_req.awvalid && axil_req.wvalid;
    // any started write holds off the read
    assign read_go  = (state == emu_pkg::axil_idle) && axil_req.arvalid
                      && !axil_req.awvalid && !axil_req.wvalid;

    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            state <= emu_pkg::axil_idle;
        end else begin
            case (state)
                emu_pkg::axil_idle: begin
                    if (write_go) begin
                        state <= emu_pkg::axil_wresp;
                    end else if (read_go) begin
                        state <= emu_pkg::axil_rdata;
                    end
                end
                emu_pkg::axil_wresp: begin
                    if (axil_req.bready) begin
                        state <= emu_pkg::axil_idle;
                    end
                end
                emu_pkg::axil_rdata: begin
                    if (axil_req.rready) begin
                        state <= emu_pkg::axil_idle;
                    end
                end
                default: begin
                    state <= emu_pkg::axil_idle;
                end
            endcase
        end
    end

    // register writes land on the handshake edge
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            run <= 1'b0;
            for (int i = 0; i < num_osc; i++) begin
                osc_cfg[i].t_hi <= emu_pkg::reset_half_period;
                osc_cfg[i].t_lo <= emu_pkg::reset_half_period;
            end
        end else if (write_go) begin
            if (axil_req.awaddr == emu_pkg::reg_ctrl && axil_req.wstrb[0]) begin
                run <= axil_req.wdata[0];
            end
            for (int i = 0; i < num_osc; i++) begin
                if (axil_req.awaddr == 8'(emu_pkg::reg_osc_base + 8 * i)) begin
                    osc_cfg[i].t_hi <= merge_half(osc_cfg[i].t_hi, axil_req.wdata,
                                                  axil_req.wstrb);
                end
                if (axil_req.awaddr == 8'(emu_pkg::reg_osc_base + 8 * i + 4)) begin
                    osc_cfg[i].t_lo <= merge_half(osc_cfg[i].t_lo, axil_req.wdata,
                                                  axil_req.wstrb);
                end
            end
        end
    end

    // read decode, unmapped addresses give 0
    always_comb begin
        rd_mux = '0;
        if (axil_req.araddr == emu_pkg::reg_ctrl) begin
            rd_mux = 32'(run);
        end
        if (axil_req.araddr == emu_pkg::reg_time) begin
            rd_mux = 32'(emu_time);
        end
        for (int i = 0; i < num_osc; i++) begin
            if (axil_req.araddr == 8'(emu_pkg::reg_osc_base + 8 * i)) begin
                rd_mux = 32'(osc_cfg[i].t_hi);
            end
            if (axil_req.araddr == 8'(emu_pkg::reg_osc_base + 8 * i + 4)) begin
                rd_mux = 32'(osc_cfg[i].t_lo);
            end
            if (axil_req.araddr == 8'(emu_pkg::reg_edge_base + 4 * i)) begin
                rd_mux = 32'(edge_cnt[i]);
            end
        end
    end

    // status values are captured with arready
    always_ff @(posedge __emu_clk) begin
        if (read_go) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = write_go;
        axil_rsp.wready  = write_go;
        axil_rsp.bvalid  = (state == emu_pkg::axil_wresp);
        axil_rsp.arready = read_go;
        axil_rsp.rvalid  = (state == emu_pkg::axil_rdata);
        axil_rsp.rdata   = rdata_q;
        // responses are always okay
        axil_rsp.bresp   = 2'b00;
        axil_rsp.rresp   = 2'b00;
    end

endmodule

`default_nettype wire

//--- hw/osc/osc_model.sv
`timescale 1ns/1ns
`default_nettype none

module osc_model (
    input  wire logic              __emu_clk,
    input  wire logic              __emu_rst,
    input  wire emu_pkg::osc_cfg_t cfg,
    input  wire emu_pkg::dt_t      emu_dt,
    output emu_pkg::dt_t           dt_req,
    output logic                   clk_val
);

    logic         step_on;
    logic         step_hit;
    emu_pkg::dt_t next_half;

    // a zero step means the emulator is stalled
    assign step_on  = (emu_dt != '0);

    // granted step reaches our next edge
    assign step_hit = step_on && (emu_dt == dt_req);

    // half period of the level we toggle into
    // going high loads t_hi, going low loads t_lo
    assign next_half = clk_val ? cfg.t_lo : cfg.t_hi;

    // dt_req holds the time left until the next toggle
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            dt_req  <= emu_pkg::reset_half_period;
            clk_val <= 1'b0;
        end else if (step_hit) begin
            clk_val <= ~clk_val;
            dt_req  <= next_half;
        end else if (step_on) begin
            // emu_dt is the global minimum so this cannot underflow
            dt_req  <= dt_req - emu_dt;
        end
    end

endmodule

`default_nettype wire

//--- hw/dt_min_select.sv
`timescale 1ns/1ns
`default_nettype none

module dt_min_select #(
    parameter int num_osc = 2
) (
    input  wire emu_pkg::dt_t [num_osc-1:0] dt_req,
    input  wire logic                       run,
    output emu_pkg::dt_t                    emu_dt
);

    emu_pkg::dt_t min_req;

    // smallest outstanding request sets the common step
    always_comb begin
        min_req = dt_req[0];
        for (int i = 1; i < num_osc; i++) begin
            if (dt_req[i] < min_req) begin
                min_req = dt_req[i];
            end
        end
    end

    // stopped emulator steps by zero
    // oscillators then hold their state
    assign emu_dt = run ? min_req : '0;

endmodule

`default_nettype wire

//--- hw/emu_status.sv
`timescale 1ns/1ns
`default_nettype none

module emu_status #(
    parameter int num_osc = 2
) (
    input  wire logic                                       __emu_clk,
    input  wire logic                                       __emu_rst,
    input  wire emu_pkg::dt_t                               emu_dt,
    input  wire logic [num_osc-1:0]                         clk_val,
    output logic [emu_pkg::time_width-1:0]                  emu_time,
    output logic [num_osc-1:0][emu_pkg::edge_cnt_width-1:0] edge_cnt
);

    logic [num_osc-1:0] clk_prev;
    logic [num_osc-1:0] rise;

    // level now high, was low one edge ago
    assign rise = clk_val & ~clk_prev;

    // emulated time, wraps at 32 bits
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            emu_time <= '0;
        end else begin
            emu_time <= emu_time + emu_pkg::time_width'(emu_dt);
        end
    end

    // per oscillator rising edge counters
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            clk_prev <= '0;
            edge_cnt <= '0;
        end else begin
            clk_prev <= clk_val;
            for (int i = 0; i < num_osc; i++) begin
                if (rise[i]) begin
                    edge_cnt[i] <= edge_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/emu_timing_top.sv
`timescale 1ns/1ns
`default_nettype none

module emu_timing_top #(
    parameter int num_osc = 2
) (
    input  wire logic               __emu_clk,
    input  wire logic               __emu_rst,
    input  wire emu_pkg::axil_req_t axil_req,
    output emu_pkg::axil_rsp_t      axil_rsp,
    output logic [num_osc-1:0]      clk_out
);

    logic                                            run;
    emu_pkg::osc_cfg_t [num_osc-1:0]                 osc_cfg;
    emu_pkg::dt_t [num_osc-1:0]                      dt_req;
    emu_pkg::dt_t                                    emu_dt;
    logic [num_osc-1:0]                              clk_val;
    logic [emu_pkg::time_width-1:0]                  emu_time;
    logic [num_osc-1:0][emu_pkg::edge_cnt_width-1:0] edge_cnt;

    // bus side, config and status readback
    axil_cfg_regs #(
        .num_osc (num_osc)
    ) regs_i (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .run       (run),
        .osc_cfg   (osc_cfg),
        .emu_time  (emu_time),
        .edge_cnt  (edge_cnt)
    );

    // one emulated oscillator per output
    for (genvar i = 0; i < num_osc; i++) begin : g_osc
        osc_model osc_i (
            .__emu_clk (__emu_clk),
            .__emu_rst (__emu_rst),
            .cfg       (osc_cfg[i]),
            .emu_dt    (emu_dt),
            .dt_req    (dt_req[i]),
            .clk_val   (clk_val[i])
        );
    end

    dt_min_select #(
        .num_osc (num_osc)
    ) min_sel_i (
        .dt_req (dt_req),
        .run    (run),
        .emu_dt (emu_dt)
    );

    emu_status #(
        .num_osc (num_osc)
    ) status_i (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst),
        .emu_dt    (emu_dt),
        .clk_val   (clk_val),
        .emu_time  (emu_time),
        .edge_cnt  (edge_cnt)
    );

    // emulated clocks straight from the oscillator flops
    assign clk_out = clk_val;

endmodule

`default_nettype wire

//--- verification/tb_emu_timing.sv
`timescale 1ns/1ns
`default_nettype none

module tb_emu_timing;

    localparam int num_osc = 2;
    localparam int clk_period = 20;
    // longest bready or rready hold-off in the back-pressure test
    localparam int max_stall = 20;
    localparam int bus_ops = 80;
    localparam int run_cycles = 300 + 20 + 30 + 100 + 50;
    localparam int watchdog_cycles = 8 + run_cycles + bus_ops * (max_stall + 8) + 500;

    logic               __emu_clk;
    logic               __emu_rst;
    emu_pkg::axil_req_t axil_req;
    emu_pkg::axil_rsp_t axil_rsp;
    logic [num_osc-1:0] clk_out;

    // reference model state
    emu_pkg::dt_t       m_rem [num_osc];
    emu_pkg::dt_t       m_hi [num_osc];
    emu_pkg::dt_t       m_lo [num_osc];
    logic [15:0]        m_cnt [num_osc];
    logic [num_osc-1:0] m_lvl;
    logic [num_osc-1:0] m_prev;
    logic               m_run;
    logic [31:0]        m_time;

    // write handshake as seen on the top ports
    logic               hs_seen = 1'b0;
    logic [7:0]         hs_addr;
    logic [31:0]        hs_data;

    int    checks = 0;
    int    errors = 0;
    int    test_errs = 0;
    int    max_wait = 3;
    bit    wave_on = 1'b0;
    string test_name = "init";

    emu_timing_top #(
        .num_osc (num_osc)
    ) dut_i (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .clk_out   (clk_out)
    );

    initial begin
        __emu_clk = 1'b0;
        forever #(clk_period / 2) __emu_clk = ~__emu_clk;
    end

    function automatic logic [7:0] osc_addr(input int i, input bit lo);
        return 8'(emu_pkg::reg_osc_base + 8 * i + (lo ? 4 : 0));
    endfunction

    function automatic logic [7:0] edge_addr(input int i);
        return 8'(emu_pkg::reg_edge_base + 4 * i);
    endfunction

    // zero half periods are stored as 1
    function automatic emu_pkg::dt_t clamp_half(input logic [31:0] data);
        emu_pkg::dt_t v;
        v = data[emu_pkg::dt_width-1:0];
        if (v == '0) begin
            v = emu_pkg::dt_t'(1);
        end
        return v;
    endfunction

    // register value the model expects at this point
    function automatic logic [31:0] model_reg(input logic [7:0] addr);
        logic [31:0] v;
        v = '0;
        if (addr == emu_pkg::reg_ctrl) begin
            v = 32'(m_run);
        end
        if (addr == emu_pkg::reg_time) begin
            v = m_time;
        end
        for (int i = 0; i < num_osc; i++) begin
            if (addr == osc_addr(i, 1'b0)) begin
                v = 32'(m_hi[i]);
            end
            if (addr == osc_addr(i, 1'b1)) begin
                v = 32'(m_lo[i]);
            end
            if (addr == edge_addr(i)) begin
                v = 32'(m_cnt[i]);
            end
        end
        return v;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // ports are settled at the falling edge
    always @(negedge __emu_clk) begin
        hs_seen = axil_rsp.awready;
        hs_addr = axil_req.awaddr;
        hs_data = axil_req.wdata;
        if (wave_on) begin
            check("clk_out", 32'(m_lvl), 32'(clk_out));
        end
    end

    // one model step per clock edge
    always @(posedge __emu_clk) begin : model_step
        emu_pkg::dt_t dt;
        if (__emu_rst) begin
            for (int i = 0; i < num_osc; i++) begin
                m_rem[i] = emu_pkg::reset_half_period;
                m_hi[i]  = emu_pkg::reset_half_period;
                m_lo[i]  = emu_pkg::reset_half_period;
                m_cnt[i] = '0;
            end
            m_lvl  = '0;
            m_prev = '0;
            m_run  = 1'b0;
            m_time = '0;
        end else begin
            // common step is the smallest request, zero when stopped
            dt = '0;
            if (m_run) begin
                dt = m_rem[0];
                for (int i = 1; i < num_osc; i++) begin
                    if (m_rem[i] < dt) begin
                        dt = m_rem[i];
                    end
                end
            end
            m_time = m_time + 32'(dt);
            for (int i = 0; i < num_osc; i++) begin
                // rise seen one edge after the level change
                if (m_lvl[i] && !m_prev[i]) begin
                    m_cnt[i] = m_cnt[i] + 16'd1;
                end
                m_prev[i] = m_lvl[i];
                if (dt != '0 && dt == m_rem[i]) begin
                    m_rem[i] = m_lvl[i] ? m_lo[i] : m_hi[i];
                    m_lvl[i] = ~m_lvl[i];
                end else if (dt != '0) begin
                    m_rem[i] = m_rem[i] - dt;
                end
            end
            // config lands after this edge's toggles used the old one
            if (hs_seen) begin
                if (hs_addr == emu_pkg::reg_ctrl) begin
                    m_run = hs_data[0];
                end
                for (int i = 0; i < num_osc; i++) begin
                    if (hs_addr == osc_addr(i, 1'b0)) begin
                        m_hi[i] = clamp_half(hs_data);
                    end
                    if (hs_addr == osc_addr(i, 1'b1)) begin
                        m_lo[i] = clamp_half(hs_data);
                    end
                end
            end
        end
    end

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge __emu_clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        @(negedge __emu_clk);
        while (!axil_rsp.awready) begin
            @(negedge __emu_clk);
        end
        // address and data channels are taken together
        check("wready", 32'd1, 32'(axil_rsp.wready));
        @(posedge __emu_clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        repeat ($urandom_range(max_wait, 0)) @(posedge __emu_clk);
        axil_req.bready <= 1'b1;
        @(negedge __emu_clk);
        while (!axil_rsp.bvalid) begin
            @(negedge __emu_clk);
        end
        check("bresp", 32'd0, 32'(axil_rsp.bresp));
        @(posedge __emu_clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic [31:0] exp);
        @(posedge __emu_clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        @(negedge __emu_clk);
        while (!axil_rsp.arready) begin
            @(negedge __emu_clk);
        end
        // status is captured on the coming arready edge
        exp = model_reg(addr);
        @(posedge __emu_clk);
        axil_req.arvalid <= 1'b0;
        repeat ($urandom_range(max_wait, 0)) @(posedge __emu_clk);
        axil_req.rready <= 1'b1;
        @(negedge __emu_clk);
        while (!axil_rsp.rvalid) begin
            @(negedge __emu_clk);
        end
        data = axil_rsp.rdata;
        check("rresp", 32'd0, 32'(axil_rsp.rresp));
        @(posedge __emu_clk);
        axil_req.rready <= 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input string what);
        logic [31:0] data;
        logic [31:0] exp;
        read_reg(addr, data, exp);
        check(what, exp, data);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        $display("test %s finished with %0d errors", test_name, errors - test_errs);
    endtask

    // new random half periods for every oscillator
    task automatic write_random_halves(input int max_half);
        for (int i = 0; i < num_osc; i++) begin
            write_reg(osc_addr(i, 1'b0), $urandom_range(max_half, 1));
            write_reg(osc_addr(i, 1'b1), $urandom_range(max_half, 1));
        end
    endtask

    task automatic read_status();
        read_check(emu_pkg::reg_time, "time");
        for (int i = 0; i < num_osc; i++) begin
            read_check(edge_addr(i), $sformatf("edges %0d", i));
        end
    endtask

    initial begin
        logic [31:0]        data;
        logic [31:0]        exp;
        logic [num_osc-1:0] held;
        void'($urandom(32'h5928));
        __emu_rst <= 1'b1;
        axil_req  <= '0;
        repeat (8) @(posedge __emu_clk);
        __emu_rst <= 1'b0;
        wave_on = 1'b1;

        start_test("reset");
        check("clk_out", 32'd0, 32'(clk_out));
        // no valid or ready is up out of reset
        check("handshake", 32'd0, 32'({axil_rsp.awready, axil_rsp.wready, axil_rsp.bvalid,
                                       axil_rsp.arready, axil_rsp.rvalid}));
        read_reg(emu_pkg::reg_ctrl, data, exp);
        check("ctrl", 32'd0, data);
        read_reg(emu_pkg::reg_time, data, exp);
        check("time", 32'd0, data);
        for (int i = 0; i < num_osc; i++) begin
            read_reg(edge_addr(i), data, exp);
            check("edges", 32'd0, data);
            read_reg(osc_addr(i, 1'b0), data, exp);
            check("t_hi", 32'd4, data);
            read_reg(osc_addr(i, 1'b1), data, exp);
            check("t_lo", 32'd4, data);
        end
        end_test();

        start_test("registers");
        write_random_halves(200);
        write_reg(osc_addr(0, 1'b0), 32'd0);
        read_reg(osc_addr(0, 1'b0), data, exp);
        check("t_hi zero", 32'd1, data);
        for (int i = 0; i < num_osc; i++) begin
            read_check(osc_addr(i, 1'b0), "t_hi");
            read_check(osc_addr(i, 1'b1), "t_lo");
        end
        read_reg(8'hfc, data, exp);
        check("unmapped", 32'd0, data);
        end_test();

        start_test("waveform");
        write_random_halves(12);
        write_reg(emu_pkg::reg_ctrl, 32'd1);
        repeat (300) @(posedge __emu_clk);
        read_check(emu_pkg::reg_time, "time");
        end_test();

        start_test("stall");
        write_reg(emu_pkg::reg_ctrl, 32'd0);
        @(negedge __emu_clk);
        held = clk_out;
        repeat (20) @(negedge __emu_clk);
        check("frozen clk_out", 32'(held), 32'(clk_out));
        read_status();
        end_test();

        start_test("reconfig");
        write_reg(emu_pkg::reg_ctrl, 32'd1);
        repeat (30) @(posedge __emu_clk);
        write_random_halves(9);
        repeat (100) @(posedge __emu_clk);
        read_status();
        end_test();

        start_test("backpressure");
        max_wait = max_stall;
        // walk t_hi and t_lo of every oscillator in turn
        for (int n = 0; n < 6; n++) begin
            write_reg(osc_addr((n / 2) % num_osc, n[0]), $urandom_range(15, 1));
            read_check(osc_addr((n / 2) % num_osc, n[0]), "half period");
        end
        read_status();
        max_wait = 3;
        end_test();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // ends a hung run
    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: the tests did not finish within %0d cycles", watchdog_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/emu_pkg.sv
hw/axil_cfg_regs.sv
hw/osc/osc_model.sv
hw/dt_min_select.sv
hw/emu_status.sv
hw/emu_timing_top.sv
verification/tb_emu_timing.sv

//--- Makefile
# Verilator build for the emulation timing core

VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_emu_timing
LINT_TOP  ?= emu_timing_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= CHECKS FAILED
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
